// ==== Makefile ====
# Verilator build and run of the fetch spill testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fetchSpillTb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb.f ====
+incdir+include
source/fetchPkg.sv
source/instrMemory.sv
source/spillController.sv
source/instrAligner.sv
source/fetchSpillTop.sv
testbench/fetchSpillTb.sv

// ==== include/fetchTbTasks.svh ====
// Stimulus, compare and directed test tasks, included inside fetchSpillTb
// Inputs change on the falling edge and outputs are sampled a quarter period later
// The fetch PC is held while memBusy or selSpillNext is high
`ifndef FETCH_TB_TASKS_SVH
`define FETCH_TB_TASKS_SVH

//////////////////////////////////////////////////
// Compare
//////////////////////////////////////////////////
task automatic compareInstr(input string name, input instrOutT got, input instrOutT exp);
  if (got !== exp) begin
    valueErrors++;
    $display("CHECK FAILED at %0t: %s got %h/%b expected %h/%b", $time, name,
             got.instr, got.compressed, exp.instr, exp.compressed);
  end
endtask

task automatic comparePc(input string name, input spillPcT got, input spillPcT exp);
  if (got !== exp) begin
    valueErrors++;
    $display("CHECK FAILED at %0t: %s got %h/%h/%b expected %h/%h/%b", $time, name,
             got.pcSpillNext, got.pcSpill, got.selSpillNext,
             exp.pcSpillNext, exp.pcSpill, exp.selSpillNext);
  end
endtask

task automatic compareBit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    valueErrors++;
    $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic compareCount(input string name, input int got, input int exp);
  if (got != exp) begin
    valueErrors++;
    $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

// Halfword at PC+2 over halfword at PC
function automatic instrOutT expectInstr(input logic [XLen-1:0] pc);
  instrOutT e;
  e.instr      = {halfAt(pc + 2), halfAt(pc)};
  e.compressed = (e.instr[1:0] != 2'b11);
  return e;
endfunction

function automatic spillPcT pcView(input logic [XLen-1:0] nextPc,
                                   input logic [XLen-1:0] memPc, input logic sel);
  spillPcT v;
  v.pcSpillNext  = nextPc;
  v.pcSpill      = memPc;
  v.selSpillNext = sel;
  return v;
endfunction

//////////////////////////////////////////////////
// Drive
//////////////////////////////////////////////////
task automatic loadImage();
  for (int i = 0; i < MemWords; i++) begin
    @(negedge clk);
    memLoad.en   = 1'b1;
    memLoad.addr = MemAddrBits'(i);
    memLoad.data = tbMem[i];
  end
  @(negedge clk);
  memLoad = '0;
endtask

task automatic driveFetch(input logic [XLen-1:0] pc, input logic [XLen-1:0] pcNext,
                          input logic stall, input logic flush);
  logic [XLen-1:0] plus4;
  plus4 = pc + 4;
  @(negedge clk);
  fetchPc.pc      = pc;
  fetchPc.pcPlus4 = plus4[XLen-1:2];
  fetchPc.pcNext  = pcNext;
  ctrl.stall      = stall;
  ctrl.flush      = flush;
  #(Quarter);
endtask

// Hold the PC until the memory word is valid
task automatic waitNotBusy(output int cycles);
  cycles = 0;
  while (memBusy && cycles < MaxBusy) begin
    cycles++;
    @(negedge clk);
    #(Quarter);
  end
  if (memBusy) begin
    otherErrors++;
    $display("At %0t memBusy stayed high for more than %0d cycles", $time, MaxBusy);
  end
endtask

// One instruction, with or without a spill
task automatic runFetch(input logic [XLen-1:0] pc, input logic expSpill, input int expBusy);
  int busyCycles;
  driveFetch(pc, pc + 4, 1'b0, 1'b0);
  waitNotBusy(busyCycles);
  compareCount("first access busy cycles", busyCycles, expBusy);
  if (expSpill) begin
    comparePc("spillPc in spill cycle", spillPc, pcView(pc + 2, pc, 1'b1));
    @(negedge clk);
    #(Quarter);
    compareBit("selSpillNext entering SPILL", spillPc.selSpillNext, expBusy != 0);
    waitNotBusy(busyCycles);
    compareCount("second access busy cycles", busyCycles, expBusy);
    comparePc("spillPc in SPILL", spillPc, pcView(pc + 4, pc + 2, 1'b0));
  end else begin
    comparePc("spillPc", spillPc, pcView(pc + 4, pc, 1'b0));
  end
  compareInstr("instrOut", instrOut, expectInstr(pc));
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////
task automatic testAligned();
  runFetch(32'h10, 1'b0, 0);
  runFetch(32'h16, 1'b0, 0);
endtask

task automatic testCachedSpill();
  runFetch(32'h1e, 1'b1, 0);
endtask

task automatic testUncachedSpill();
  runFetch(32'(UncachedBase + 6), 1'b1, UncachedWait);
endtask

task automatic testCompressedLineEnd();
  runFetch(32'h4e, 1'b0, 0);
endtask

task automatic testStallFlush();
  logic [XLen-1:0] pc;
  pc = 32'h2e;
  driveFetch(pc, pc + 4, 1'b0, 1'b0);
  comparePc("spillPc in spill cycle", spillPc, pcView(pc + 2, pc, 1'b1));
  // Stall keeps SPILL and the merged word until the last pass drops it
  for (int i = 0; i < 4; i++) begin
    driveFetch(pc, pc + 4, i < 3, 1'b0);
    comparePc("spillPc while stalled", spillPc, pcView(pc + 4, pc + 2, 1'b0));
    compareInstr("instrOut while stalled", instrOut, expectInstr(pc));
  end
  // Flush in the spill cycle redirects to pcNext
  pc = 32'h3e;
  driveFetch(pc, 32'h100, 1'b0, 1'b1);
  comparePc("spillPc on flush", spillPc, pcView(32'h100, pc, 1'b1));
  runFetch(32'h100, 1'b0, 0);
endtask

`endif

// ==== testbench/fetchSpillTb.sv ====
// Directed testbench for the fetch spill front end
// Plays the fetch stage and preloads the whole memory through the load port
// Expected instructions come from a local copy of the memory image
`timescale 1ns/1ps
`default_nettype none

module fetchSpillTb import fetchPkg::*; ();

  localparam int ClkPeriod  = 4;
  localparam int Quarter    = ClkPeriod / 4;
  localparam int NumTests   = 5;
  localparam int MaxBusy    = 4 * UncachedWait + 4;
  // Reset and preload first, then a fixed budget for each test
  localparam int WatchdogNs = (MemWords + 8) * ClkPeriod + NumTests * 200;

  logic        clk;
  logic        arstN;
  fetchPcT     fetchPc;
  fetchCtrlT   ctrl;
  memLoadT     memLoad;
  spillPcT     spillPc;
  instrOutT    instrOut;
  logic        memBusy;
  logic [31:0] tbMem [MemWords];
  int          valueErrors;
  int          otherErrors;

  fetchSpillTop i_fetchSpillTop (
    .clk      (clk),
    .arstN    (arstN),
    .fetchPc  (fetchPc),
    .ctrl     (ctrl),
    .memLoad  (memLoad),
    .spillPc  (spillPc),
    .instrOut (instrOut),
    .memBusy  (memBusy)
  );

  //////////////////////////////////////////////////
  // Memory image
  //////////////////////////////////////////////////
  // Halfword at a byte address, wrapping like the memory index
  function automatic logic [15:0] halfAt(input logic [XLen-1:0] addr);
    logic [31:0] word;
    word = tbMem[addr[MemAddrBits+1:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  // Force the low two bits of the halfword at addr
  function automatic void setKind(input logic [XLen-1:0] addr, input logic is32);
    logic [MemAddrBits-1:0] w;
    w = addr[MemAddrBits+1:2];
    if (addr[1]) begin
      tbMem[w][17:16] = is32 ? 2'b11 : 2'b01;
    end else begin
      tbMem[w][1:0] = is32 ? 2'b11 : 2'b01;
    end
  endfunction

  function automatic void fillImage();
    for (int i = 0; i < MemWords; i++) begin
      tbMem[i] = $urandom();
    end
    // Instruction kinds the directed tests rely on
    setKind(32'h10, 1'b1);
    setKind(32'h16, 1'b0);
    setKind(32'h1e, 1'b1);
    setKind(32'h2e, 1'b1);
    setKind(32'h3e, 1'b1);
    setKind(32'h4e, 1'b0);
    setKind(32'(UncachedBase + 6), 1'b1);
  endfunction

  `include "fetchTbTasks.svh"

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, a test did not finish", WatchdogNs);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h2d0f));
    valueErrors = 0;
    otherErrors = 0;
    arstN       = 1'b0;
    fetchPc     = '0;
    ctrl        = '0;
    memLoad     = '0;
    fillImage();
    repeat (3) @(negedge clk);
    arstN = 1'b1;
    loadImage();
    testAligned();
    testCachedSpill();
    testUncachedSpill();
    testCompressedLineEnd();
    testStallFlush();
    @(negedge clk);
    $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/fetchSpillTop.sv ====
// Fetch spill front end where memory and spill controller share the spill PC
// and the aligner merges their results
// memBusy is the raw memory busy level
`timescale 1ns/1ps
`default_nettype none

module fetchSpillTop import fetchPkg::*; (
  input  wire logic      clk,
  input  wire logic      arstN,
  input  wire fetchPcT   fetchPc,
  input  wire fetchCtrlT ctrl,
  input  wire memLoadT   memLoad,
  output spillPcT        spillPc,
  output instrOutT       instrOut,
  output logic           memBusy
);

  rawFetchT   rawFetch;
  spillStateT spillState;
  logic       earlyCompressed;

  //////////////////////////////////////////////////
  // Memory on the spill PC
  //////////////////////////////////////////////////
  instrMemory i_instrMemory (
    .clk     (clk),
    .arstN   (arstN),
    .pcSpill (spillPc.pcSpill),
    .load    (memLoad),
    .fetch   (rawFetch)
  );

  // Controller
  spillController i_spillController (
    .clk             (clk),
    .arstN           (arstN),
    .fetchPc         (fetchPc),
    .ctrl            (ctrl),
    .fetch           (rawFetch),
    .earlyCompressed (earlyCompressed),
    .spillPc         (spillPc),
    .state           (spillState)
  );

  // Aligner
  instrAligner i_instrAligner (
    .clk             (clk),
    .arstN           (arstN),
    .fetch           (rawFetch),
    .state           (spillState),
    .instrOut        (instrOut),
    .earlyCompressed (earlyCompressed)
  );

  assign memBusy = rawFetch.busy;

endmodule

`default_nettype wire

// ==== source/instrAligner.sv ====
// Joins the two halves of a spilled instruction
// The first half is captured at the end of the first access
// Compressed means the low two bits are not both ones
`timescale 1ns/1ps
`default_nettype none

module instrAligner import fetchPkg::*; (
  input  wire logic       clk,
  input  wire logic       arstN,
  input  wire rawFetchT   fetch,
  input  wire spillStateT state,
  output instrOutT        instrOut,
  output logic            earlyCompressed
);

  logic [15:0] firstHalf;
  logic [31:0] merged;

  //////////////////////////////////////////////////
  // First half capture
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      firstHalf <= '0;
    end else if (state.spillSave) begin
      firstHalf <= fetch.instrRaw[15:0];
    end
  end

  //////////////////////////////////////////////////
  // Merge
  //////////////////////////////////////////////////
  // Second access brings the upper half in its low halfword
  assign merged = state.selSpill ? {fetch.instrRaw[15:0], firstHalf} : fetch.instrRaw;

  assign instrOut.instr      = merged;
  assign instrOut.compressed = (merged[1:0] != 2'b11);

  // Raw check used before the spill decision
  assign earlyCompressed = (fetch.instrRaw[1:0] != 2'b11);

endmodule

`default_nettype wire

// ==== source/spillController.sv ====
// Detects fetches that cross a line (cacheable) or a word (uncached)
// and issues the second access at PC+2
// The fetch stage must hold its PC while selSpillNext or busy is high
// SPILL is also held while the second access is busy
`timescale 1ns/1ps
`default_nettype none

module spillController import fetchPkg::*; (
  input  wire logic       clk,
  input  wire logic       arstN,
  input  wire fetchPcT    fetchPc,
  input  wire fetchCtrlT  ctrl,
  input  wire rawFetchT   fetch,
  input  wire logic       earlyCompressed,
  output spillPcT         spillPc,
  output spillStateT      state
);

  typedef enum logic {StReady, StSpill} stateT;

  stateT           curState;
  stateT           nextState;
  logic [XLen-1:0] pcPlus2Next;
  logic [XLen-1:0] pcPlus2;
  logic            spillCached;
  logic            spillUncached;
  logic            spill;
  logic            takeSpill;
  logic            selSpill;
  logic            selSpillNext;
  logic            spillSave;

  //////////////////////////////////////////////////
  // PC selection
  //////////////////////////////////////////////////
  // PC+2 reuses the PC+4 adder when bit 1 is set
  assign pcPlus2Next = fetchPc.pc[1] ? {fetchPc.pcPlus4, 2'b00}
                                     : {fetchPc.pc[XLen-1:2], 2'b10};

  // Registered copy cuts the adder out of the memory address path
  always_ff @(posedge clk) begin
    pcPlus2 <= pcPlus2Next;
  end

  // Flush wins over the spill redirect
  assign spillPc.pcSpillNext  = (selSpillNext & ~ctrl.flush) ? pcPlus2Next : fetchPc.pcNext;
  assign spillPc.pcSpill      = selSpill ? pcPlus2 : fetchPc.pc;
  assign spillPc.selSpillNext = selSpillNext;

  //////////////////////////////////////////////////
  // Spill detection
  //////////////////////////////////////////////////
  // Last halfword of the line
  assign spillCached   = &fetchPc.pc[LineOffBits-1:1];
  // Upper halfword of the word
  assign spillUncached = fetchPc.pc[1];
  assign spill         = fetch.cacheable ? spillCached : spillUncached;

  // Compressed halfwords fit, and a busy first access is not yet valid
  assign takeSpill = spill & ~earlyCompressed & ~fetch.busy;

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      curState <= StReady;
    end else if (ctrl.flush) begin
      curState <= StReady;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      StReady: begin
        if (takeSpill) begin
          nextState = StSpill;
        end
      end
      StSpill: begin
        // Busy acts like a stall from the fetch side
        if (!ctrl.stall && !fetch.busy) begin
          nextState = StReady;
        end
      end
      default: nextState = StReady;
    endcase
  end

  assign selSpill     = (curState == StSpill);
  assign selSpillNext = ((curState == StReady) & takeSpill) |
                        ((curState == StSpill) & fetch.busy);
  assign spillSave    = (curState == StReady) & takeSpill & ~ctrl.flush;

  assign state.selSpill  = selSpill;
  assign state.spillSave = spillSave;

  // SPILL follows only a taken, unflushed spill
  spillEntry: assert property (@(posedge clk) disable iff (!arstN)
    $rose(selSpill) |-> $past(takeSpill && !ctrl.flush))
    else $error("spillController entered SPILL without a taken spill");

endmodule

`default_nettype wire

// ==== source/instrMemory.sv ====
// Word memory read as a 32-bit window starting at any halfword
// The window wraps at the top of the array; upper address bits are ignored
// Uncached reads stall only when the uncached address changes
// UncachedWait must be at least 1
`timescale 1ns/1ps
`default_nettype none

module instrMemory import fetchPkg::*; (
  input  wire logic            clk,
  input  wire logic            arstN,
  input  wire logic [XLen-1:0] pcSpill,
  input  wire memLoadT         load,
  output rawFetchT             fetch
);

  logic [31:0]            mem [MemWords];
  logic [MemAddrBits-1:0] wordAddr;
  logic [MemAddrBits-1:0] nextWordAddr;
  logic [31:0]            loWord;
  logic [31:0]            hiWord;
  logic                   cacheable;
  logic                   newReq;
  logic [XLen-1:0]        lastAddr;
  logic [WaitBits-1:0]    waitCnt;

  //////////////////////////////////////////////////
  // Storage and read window
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end
  end

  assign wordAddr     = pcSpill[MemAddrBits+1:2];
  assign nextWordAddr = wordAddr + MemAddrBits'(1);
  assign loWord       = mem[wordAddr];
  assign hiWord       = mem[nextWordAddr];

  // Odd halfword takes the upper half of this word and the lower half of the next
  assign fetch.instrRaw = pcSpill[1] ? {hiWord[15:0], loWord[31:16]} : loWord;

  //////////////////////////////////////////////////
  // Region and wait counter
  //////////////////////////////////////////////////
  assign cacheable       = (pcSpill < XLen'(UncachedBase));
  assign fetch.cacheable = cacheable;

  // New uncached access
  // lastAddr resets to a cacheable address, so the first uncached fetch always waits
  assign newReq = ~cacheable & (pcSpill != lastAddr);

  // Busy from the first cycle of a new access until the count runs out
  assign fetch.busy = newReq | (waitCnt != '0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lastAddr <= '0;
      waitCnt  <= '0;
    end else if (newReq) begin
      lastAddr <= pcSpill;
      waitCnt  <= WaitBits'(UncachedWait - 1);
    end else if (waitCnt != '0) begin
      waitCnt <= waitCnt - WaitBits'(1);
    end
  end

  // An uncached address is held until its word is valid
  addrHeldWhileWaiting: assert property (@(posedge clk) disable iff (!arstN)
    (waitCnt != '0) |-> (pcSpill == lastAddr))
    else $error("instrMemory address changed while an uncached access was busy");

endmodule

`default_nettype wire

// ==== source/fetchPkg.sv ====
// Shared widths, geometry and bundles for the fetch spill front end
// Line size and memory depth must be powers of two
// Addresses at or above UncachedBase are uncached and pay UncachedWait busy cycles
`default_nettype none

package fetchPkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////
  localparam int XLen         = 32;
  localparam int LineBytes    = 16;
  // Byte offset bits inside one cache line
  localparam int LineOffBits  = $clog2(LineBytes);
  localparam int MemWords     = 256;
  localparam int MemAddrBits  = $clog2(MemWords);
  localparam int UncachedBase = 512;
  localparam int UncachedWait = 2;
  localparam int WaitBits     = $clog2(UncachedWait + 1);

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////
  // Decode stage control
  typedef struct packed {
    logic stall;
    logic flush;
  } fetchCtrlT;

  // PC values from the fetch stage
  typedef struct packed {
    logic [XLen-1:0] pc;
    logic [XLen-1:2] pcPlus4;
    logic [XLen-1:0] pcNext;
  } fetchPcT;

  // Preload port of the instruction memory
  typedef struct packed {
    logic                   en;
    logic [MemAddrBits-1:0] addr;
    logic [31:0]            data;
  } memLoadT;

  // Spill adjusted PCs
  typedef struct packed {
    logic [XLen-1:0] pcSpillNext;
    logic [XLen-1:0] pcSpill;
    logic            selSpillNext;
  } spillPcT;

  // Controller to aligner
  typedef struct packed {
    logic selSpill;
    logic spillSave;
  } spillStateT;

  // Memory response
  typedef struct packed {
    logic [31:0] instrRaw;
    logic        busy;
    logic        cacheable;
  } rawFetchT;

  // Final instruction
  typedef struct packed {
    logic [31:0] instr;
    logic        compressed;
  } instrOutT;

endpackage

`default_nettype wire
